// ==== logic/cache_pkg.sv ====
package cache_pkg;

    // cache geometry
    // 4 ways x 64 sets x 16 banks of 4 bytes
    localparam int num_ways       = 4;
    localparam int num_sets       = 64;
    localparam int words_per_line = 16;

    // address split
    // tag 31:12, set 11:6, bank 5:2
    localparam int index_w = 6;
    localparam int bank_w  = 4;
    localparam int tag_w   = 20;

    // one full line, bank 0 in the low word
    typedef logic [511:0] line_t;

    // one enable per byte of a line
    typedef logic [63:0] line_be_t;

    // one-hot way select
    typedef logic [num_ways-1:0] way_sel_t;

    // one wishbone request
    // same layout on the cpu and memory side
    typedef struct packed {
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
        logic        we;
    } wb_req_t;

    // controller states
    typedef enum logic [2:0] {
        idle,
        // tag compare, array read
        lookup,
        // sixteen single-word reads into the victim way
        refill,
        // one memory write per cpu write
        write_through,
        // single-cycle cpu ack
        respond
    } ctrl_state_e;

endpackage

// ==== logic/cache_memory.sv ====
`timescale 1ns/10ps

module cache_memory (
    input  logic                                clk,
    input  logic [cache_pkg::index_w-1:0]       wr_index,
    input  cache_pkg::line_t                    din,
    input  logic                                en,
    input  cache_pkg::line_be_t                 we,
    input  logic [cache_pkg::index_w-1:0]       rd_index,
    output cache_pkg::line_t                    dout
);

    // one way, one line per set
    cache_pkg::line_t mem [cache_pkg::num_sets];

    // write port, byte granular, only when this way is enabled
    always_ff @(posedge clk) begin
        if (en) begin
            for (int b = 0; b < $bits(cache_pkg::line_be_t); b++) begin
                if (we[b]) begin
                    mem[wr_index][8*b +: 8] <= din[8*b +: 8];
                end
            end
        end
    end

    // read port, data one cycle after the index
    // a same-edge write shows up on the next read
    always_ff @(posedge clk) begin
        dout <= mem[rd_index];
    end

endmodule

// ==== logic/memory.sv ====
`timescale 1ns/10ps

module memory (
    input  logic                                            clk,
    input  logic [31:0]                                     r_addr,
    input  logic [31:0]                                     w_addr,
    input  cache_pkg::line_t                                mem_din,
    input  cache_pkg::line_be_t                             mem_we,
    input  cache_pkg::way_sel_t                             mem_en,
    output cache_pkg::line_t [cache_pkg::num_ways-1:0]      mem_dout
);

    logic [cache_pkg::index_w-1:0] r_index;
    logic [cache_pkg::index_w-1:0] w_index;

    // set index sits right above the 64-byte line offset
    assign r_index = r_addr[6 +: cache_pkg::index_w];
    assign w_index = w_addr[6 +: cache_pkg::index_w];

    // all ways see the same data and byte enables
    // only the enabled way takes the write
    // every way is read each cycle, controller picks the hit way
    for (genvar w = 0; w < cache_pkg::num_ways; w++) begin : g_way
        cache_memory u_way (
            .clk      (clk),
            .wr_index (w_index),
            .din      (mem_din),
            .en       (mem_en[w]),
            .we       (mem_we),
            .rd_index (r_index),
            .dout     (mem_dout[w])
        );
    end

endmodule

// ==== logic/tag_store.sv ====
`timescale 1ns/10ps

module tag_store (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic [31:0]             lookup_adr,
    input  logic                    fill_done,
    output logic                    hit,
    output cache_pkg::way_sel_t     hit_way,
    output cache_pkg::way_sel_t     victim_way
);

    // per-way tags, no reset, qualified by valid
    logic [cache_pkg::tag_w-1:0] tags [cache_pkg::num_ways][cache_pkg::num_sets];

    // per-set valid bits, one per way
    cache_pkg::way_sel_t valid [cache_pkg::num_sets];

    // round-robin pointer per set
    logic [$clog2(cache_pkg::num_ways)-1:0] rr_ptr [cache_pkg::num_sets];

    logic [cache_pkg::index_w-1:0] set;
    logic [cache_pkg::tag_w-1:0]   tag;

    assign set = lookup_adr[6 +: cache_pkg::index_w];
    assign tag = lookup_adr[31 -: cache_pkg::tag_w];

    // compare all four ways of the set at once
    always_comb begin
        for (int w = 0; w < cache_pkg::num_ways; w++) begin
            hit_way[w] = valid[set][w] && (tags[w][set] == tag);
        end
    end

    assign hit = |hit_way;

    // victim is where the set pointer sits now
    assign victim_way = cache_pkg::way_sel_t'(1) << rr_ptr[set];

    // tag install on the last refill beat
    always_ff @(posedge clk) begin
        if (fill_done) begin
            tags[rr_ptr[set]][set] <= tag;
        end
    end

    // valid and pointer update
    // pointer wraps after the last way
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < cache_pkg::num_sets; s++) begin
                valid[s]  <= '0;
                rr_ptr[s] <= '0;
            end
        end else if (fill_done) begin
            valid[set][rr_ptr[set]] <= 1'b1;
            rr_ptr[set]             <= rr_ptr[set] + 1'b1;
        end
    end

endmodule

// ==== logic/mem_wr_ctrl.sv ====
`timescale 1ns/10ps

module mem_wr_ctrl (
    input  logic [31:0]                     wr_word,
    input  logic [3:0]                      wr_sel,
    input  logic [cache_pkg::bank_w-1:0]    wr_bank,
    input  logic                            wr_valid,
    output cache_pkg::line_t                line_din,
    output cache_pkg::line_be_t             line_be
);

    // same word in every bank
    // byte enables decide which bank actually changes
    assign line_din = {cache_pkg::words_per_line{wr_word}};

    // four enables per bank
    // wr_sel lands on the addressed bank only
    always_comb begin
        line_be = '0;
        if (wr_valid) begin
            line_be[4*wr_bank +: 4] = wr_sel;
        end
    end

endmodule

// ==== logic/cache_ctrl.sv ====
`timescale 1ns/10ps

module cache_ctrl (
    input  logic                                        clk,
    input  logic                                        arst_n,
    // cpu side, wishbone slave
    input  logic                                        cpu_cyc,
    input  logic                                        cpu_stb,
    input  cache_pkg::wb_req_t                          cpu_req,
    output logic                                        cpu_ack,
    output logic [31:0]                                 cpu_dat_r,
    // memory side, wishbone master
    output logic                                        mem_cyc,
    output logic                                        mem_stb,
    output cache_pkg::wb_req_t                          mem_req,
    input  logic                                        mem_ack,
    input  logic [31:0]                                 mem_dat_r,
    // tag store
    output logic [31:0]                                 lookup_adr,
    input  logic                                        hit,
    input  cache_pkg::way_sel_t                         hit_way,
    input  cache_pkg::way_sel_t                         victim_way,
    output logic                                        fill_done,
    // data array write path
    output cache_pkg::way_sel_t                         way_en,
    output logic [31:0]                                 wr_word,
    output logic [3:0]                                  wr_sel,
    output logic [cache_pkg::bank_w-1:0]                wr_bank,
    output logic                                        wr_valid,
    input  cache_pkg::line_t [cache_pkg::num_ways-1:0]  mem_dout
);

    cache_pkg::ctrl_state_e         state;
    cache_pkg::wb_req_t             req_q;
    logic [cache_pkg::bank_w-1:0]   beat;
    logic                           mem_done;
    logic [31:0]                    refill_adr;

    // memory transfer finishes on this edge
    assign mem_done = mem_stb && mem_ack;

    // line base plus beat offset
    assign refill_adr = {req_q.adr[31:6], beat, 2'b00};

    // refill address during a refill, else the held cpu address
    assign lookup_adr = (state == cache_pkg::refill) ? refill_adr : req_q.adr;

    // last beat installs the tag and moves the set pointer
    assign fill_done = (state == cache_pkg::refill) && mem_done && (beat == '1);

    assign cpu_ack = (state == cache_pkg::respond);

    // cpu request capture, no reset on payload
    always_ff @(posedge clk) begin
        if (state == cache_pkg::idle && cpu_cyc && cpu_stb) begin
            req_q <= cpu_req;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= cache_pkg::idle;
            mem_cyc <= 1'b0;
            mem_stb <= 1'b0;
            beat    <= '0;
        end else begin
            unique case (state)
                cache_pkg::idle: begin
                    if (cpu_cyc && cpu_stb) begin
                        state <= cache_pkg::lookup;
                    end
                end
                cache_pkg::lookup: begin
                    // writes always go to memory, hit or not
                    if (req_q.we) begin
                        state   <= cache_pkg::write_through;
                        mem_cyc <= 1'b1;
                        mem_stb <= 1'b1;
                    end else if (hit) begin
                        state <= cache_pkg::respond;
                    end else begin
                        state   <= cache_pkg::refill;
                        mem_cyc <= 1'b1;
                        mem_stb <= 1'b1;
                        beat    <= '0;
                    end
                end
                cache_pkg::refill: begin
                    if (mem_done) begin
                        // stb low for one cycle between beats
                        mem_stb <= 1'b0;
                        beat    <= beat + 1'b1;
                        if (beat == '1) begin
                            // retry the lookup, now a hit
                            mem_cyc <= 1'b0;
                            state   <= cache_pkg::lookup;
                        end
                    end else if (!mem_stb) begin
                        mem_stb <= 1'b1;
                    end
                end
                cache_pkg::write_through: begin
                    if (mem_done) begin
                        mem_cyc <= 1'b0;
                        mem_stb <= 1'b0;
                        state   <= cache_pkg::respond;
                    end
                end
                cache_pkg::respond: begin
                    state <= cache_pkg::idle;
                end
                default: begin
                    state <= cache_pkg::idle;
                end
            endcase
        end
    end

    // memory request, stable until acked
    // refill beats are full-word reads
    always_comb begin
        mem_req = req_q;
        if (state == cache_pkg::refill) begin
            mem_req.adr = refill_adr;
            mem_req.dat = '0;
            mem_req.sel = 4'hf;
            mem_req.we  = 1'b0;
        end
    end

    // array writes happen on the acked edge
    // refill beat into the victim way, write hit into the hit way
    always_comb begin
        way_en   = '0;
        wr_word  = req_q.dat;
        wr_sel   = req_q.sel;
        wr_bank  = req_q.adr[2 +: cache_pkg::bank_w];
        wr_valid = 1'b0;
        if (state == cache_pkg::refill && mem_done) begin
            way_en   = victim_way;
            wr_word  = mem_dat_r;
            wr_sel   = 4'hf;
            wr_bank  = beat;
            wr_valid = 1'b1;
        end else if (state == cache_pkg::write_through && mem_done && hit) begin
            way_en   = hit_way;
            wr_valid = 1'b1;
        end
    end

    // way and bank mux
    // array output was registered at the end of lookup
    always_comb begin
        cpu_dat_r = '0;
        for (int w = 0; w < cache_pkg::num_ways; w++) begin
            if (hit_way[w]) begin
                cpu_dat_r |= mem_dout[w][32*req_q.adr[2 +: cache_pkg::bank_w] +: 32];
            end
        end
    end

endmodule

// ==== logic/cache_top.sv ====
`timescale 1ns/10ps

module cache_top (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    cpu_cyc,
    input  logic                    cpu_stb,
    input  cache_pkg::wb_req_t      cpu_req,
    output logic                    cpu_ack,
    output logic [31:0]             cpu_dat_r,
    output logic                    mem_cyc,
    output logic                    mem_stb,
    output cache_pkg::wb_req_t      mem_req,
    input  logic                    mem_ack,
    input  logic [31:0]             mem_dat_r
);

    logic [31:0]                                lookup_adr;
    logic                                       hit;
    cache_pkg::way_sel_t                        hit_way;
    cache_pkg::way_sel_t                        victim_way;
    logic                                       fill_done;
    cache_pkg::way_sel_t                        way_en;
    logic [31:0]                                wr_word;
    logic [3:0]                                 wr_sel;
    logic [cache_pkg::bank_w-1:0]               wr_bank;
    logic                                       wr_valid;
    cache_pkg::line_t                           line_din;
    cache_pkg::line_be_t                        line_be;
    cache_pkg::line_t [cache_pkg::num_ways-1:0] mem_dout;

    cache_ctrl u_ctrl (
        .clk        (clk),
        .arst_n     (arst_n),
        .cpu_cyc    (cpu_cyc),
        .cpu_stb    (cpu_stb),
        .cpu_req    (cpu_req),
        .cpu_ack    (cpu_ack),
        .cpu_dat_r  (cpu_dat_r),
        .mem_cyc    (mem_cyc),
        .mem_stb    (mem_stb),
        .mem_req    (mem_req),
        .mem_ack    (mem_ack),
        .mem_dat_r  (mem_dat_r),
        .lookup_adr (lookup_adr),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim_way (victim_way),
        .fill_done  (fill_done),
        .way_en     (way_en),
        .wr_word    (wr_word),
        .wr_sel     (wr_sel),
        .wr_bank    (wr_bank),
        .wr_valid   (wr_valid),
        .mem_dout   (mem_dout)
    );

    tag_store u_tags (
        .clk        (clk),
        .arst_n     (arst_n),
        .lookup_adr (lookup_adr),
        .fill_done  (fill_done),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim_way (victim_way)
    );

    mem_wr_ctrl u_wr (
        .wr_word  (wr_word),
        .wr_sel   (wr_sel),
        .wr_bank  (wr_bank),
        .wr_valid (wr_valid),
        .line_din (line_din),
        .line_be  (line_be)
    );

    // read and write share the lookup address
    memory u_data (
        .clk      (clk),
        .r_addr   (lookup_adr),
        .w_addr   (lookup_adr),
        .mem_din  (line_din),
        .mem_we   (line_be),
        .mem_en   (way_en),
        .mem_dout (mem_dout)
    );

endmodule

// ==== verification/cache_asserts.sv ====
`timescale 1ns/10ps

module cache_asserts (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    mem_cyc,
    input  logic                    mem_stb,
    input  cache_pkg::wb_req_t      mem_req,
    input  logic                    mem_ack,
    input  logic                    cpu_ack,
    input  cache_pkg::way_sel_t     way_en
);

    // strobe only inside a cycle
    a_stb_in_cyc: assert property (@(posedge clk) disable iff (!arst_n)
        mem_stb |-> mem_cyc)
        else $error("mem_stb high without mem_cyc");

    // request held until the slave acks
    a_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
        mem_stb && !mem_ack |=> mem_stb && $stable(mem_req))
        else $error("memory request changed before ack");

    a_ack_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        cpu_ack |=> !cpu_ack)
        else $error("cpu_ack longer than one cycle");

    // at most one way written per edge
    a_way_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(way_en))
        else $error("way_en not one-hot");

endmodule

bind cache_ctrl cache_asserts u_asserts (
    .clk     (clk),
    .arst_n  (arst_n),
    .mem_cyc (mem_cyc),
    .mem_stb (mem_stb),
    .mem_req (mem_req),
    .mem_ack (mem_ack),
    .cpu_ack (cpu_ack),
    .way_en  (way_en)
);

// ==== verification/cache_tb.sv ====
`timescale 1ns/10ps

module cache_tb;

    logic                   clk = 1'b0;
    logic                   arst_n;
    logic                   cpu_cyc;
    logic                   cpu_stb;
    cache_pkg::wb_req_t     cpu_req;
    logic                   cpu_ack;
    logic [31:0]            cpu_dat_r;
    logic                   mem_cyc;
    logic                   mem_stb;
    cache_pkg::wb_req_t     mem_req;
    logic                   mem_ack = 1'b0;
    logic [31:0]            mem_dat_r = '0;

    // 64 KiB backing store, word addressed by adr[15:2]
    logic [31:0]            mem_model [16384];
    cache_pkg::wb_req_t     req_log [$];
    int                     rd_count;
    int                     wr_count;
    int                     ack_delay;

    // tag and pointer model of the cache
    logic [cache_pkg::tag_w-1:0] ref_tag [cache_pkg::num_ways][cache_pkg::num_sets];
    bit                          ref_valid [cache_pkg::num_ways][cache_pkg::num_sets];
    int                          ref_ptr [cache_pkg::num_sets];

    int checks;
    int errors;
    int rand_ops = 40;

    cache_top dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .cpu_cyc   (cpu_cyc),
        .cpu_stb   (cpu_stb),
        .cpu_req   (cpu_req),
        .cpu_ack   (cpu_ack),
        .cpu_dat_r (cpu_dat_r),
        .mem_cyc   (mem_cyc),
        .mem_stb   (mem_stb),
        .mem_req   (mem_req),
        .mem_ack   (mem_ack),
        .mem_dat_r (mem_dat_r)
    );

    // 4 ns period
    always #2 clk = ~clk;

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return (a * 32'h9e37_79b1) ^ 32'h5a3c_96e1;
    endfunction

    function automatic logic [31:0] line_addr(input int tag, input int set);
        return 32'((tag << 12) | (set << 6));
    endfunction

    // memory slave, random 0..3 cycle ack delay
    // also the transfer monitor
    always @(negedge clk) begin
        cache_pkg::wb_req_t r;
        if (!arst_n) begin
            mem_ack = 1'b0;
            ack_delay = -1;
        end else if (mem_ack) begin
            mem_ack = 1'b0;
        end else if (mem_cyc && mem_stb) begin
            if (ack_delay < 0) begin
                ack_delay = int'($urandom % 4);
            end
            if (ack_delay == 0) begin
                r = mem_req;
                if (r.we) begin
                    for (int b = 0; b < 4; b++) begin
                        if (r.sel[b]) begin
                            mem_model[r.adr[15:2]][8*b +: 8] = r.dat[8*b +: 8];
                        end
                    end
                    wr_count++;
                end else begin
                    mem_dat_r = mem_model[r.adr[15:2]];
                    // write data is a don't care on reads
                    r.dat = '0;
                    rd_count++;
                end
                req_log.push_back(r);
                mem_ack = 1'b1;
                ack_delay = -1;
            end else begin
                ack_delay--;
            end
        end
    end

    // budget of 200 cycles per cpu access, plus the two resets
    initial begin
        int num_accesses;
        num_accesses = 4 + 3 + 2 + 9 + rand_ops + 16;
        repeat (200 * num_accesses + 64) @(posedge clk);
        $display("watchdog: run did not finish within %0d cpu accesses", num_accesses);
        $display("TEST FAILED");
        $finish;
    end

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_req(input string name, input cache_pkg::wb_req_t got,
                               input cache_pkg::wb_req_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s got adr=%h dat=%h sel=%h we=%b expected adr=%h dat=%h sel=%h we=%b",
                     $time, name, got.adr, got.dat, got.sel, got.we,
                     exp.adr, exp.dat, exp.sel, exp.we);
        end
    endtask

    task automatic compare_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("FAIL t=%0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    function automatic bit model_hit(input logic [31:0] adr);
        logic [cache_pkg::index_w-1:0] set;
        bit found;
        set = adr[6 +: cache_pkg::index_w];
        found = 1'b0;
        for (int w = 0; w < cache_pkg::num_ways; w++) begin
            if (ref_valid[w][set] && ref_tag[w][set] == adr[31:12]) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    // fill goes to the pointer way, then pointer moves on
    task automatic model_fill(input logic [31:0] adr);
        logic [cache_pkg::index_w-1:0] set;
        set = adr[6 +: cache_pkg::index_w];
        ref_tag[ref_ptr[set]][set] = adr[31:12];
        ref_valid[ref_ptr[set]][set] = 1'b1;
        ref_ptr[set] = (ref_ptr[set] + 1) % cache_pkg::num_ways;
    endtask

    task automatic model_reset();
        for (int s = 0; s < cache_pkg::num_sets; s++) begin
            ref_ptr[s] = 0;
            for (int w = 0; w < cache_pkg::num_ways; w++) begin
                ref_valid[w][s] = 1'b0;
            end
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        arst_n = 1'b0;
        repeat (16) @(negedge clk);
        compare_count("cpu_ack in reset", int'(cpu_ack), 0);
        compare_count("mem_cyc in reset", int'(mem_cyc), 0);
        compare_count("mem_stb in reset", int'(mem_stb), 0);
        arst_n = 1'b1;
        model_reset();
    endtask

    // one wishbone classic cycle, held until ack
    // waits counts falling edges from request to ack seen
    task automatic cpu_access(input cache_pkg::wb_req_t req, output logic [31:0] rdata,
                              output int waits);
        @(negedge clk);
        cpu_cyc = 1'b1;
        cpu_stb = 1'b1;
        cpu_req = req;
        waits = 0;
        do begin
            @(negedge clk);
            waits++;
        end while (!cpu_ack);
        rdata = cpu_dat_r;
        cpu_cyc = 1'b0;
        cpu_stb = 1'b0;
    endtask

    task automatic check_read(input logic [31:0] adr);
        cache_pkg::wb_req_t req;
        cache_pkg::wb_req_t exp;
        logic [31:0] rdata;
        int waits;
        int rd0;
        int wr0;
        int log0;
        bit exp_hit;
        exp_hit = model_hit(adr);
        rd0 = rd_count;
        wr0 = wr_count;
        log0 = req_log.size();
        req.adr = adr;
        req.dat = '0;
        req.sel = 4'hf;
        req.we = 1'b0;
        cpu_access(req, rdata, waits);
        compare_word("cpu_dat_r", rdata, mem_model[adr[15:2]]);
        compare_count("memory writes", wr_count - wr0, 0);
        if (exp_hit) begin
            compare_count("memory reads", rd_count - rd0, 0);
            compare_count("ack wait states", waits - 1, 1);
        end else begin
            compare_count("memory reads", rd_count - rd0, cache_pkg::words_per_line);
            // beats in order from the line base
            exp = req;
            for (int b = 0; b < 16 && log0 + b < req_log.size(); b++) begin
                exp.adr = {adr[31:6], 6'b0} + 32'(4 * b);
                compare_req("mem_req", req_log[log0 + b], exp);
            end
            model_fill(adr);
        end
    endtask

    // no allocation, tag model stays as it is
    task automatic check_write(input logic [31:0] adr, input logic [31:0] dat,
                               input logic [3:0] sel);
        cache_pkg::wb_req_t req;
        logic [31:0] rdata;
        int waits;
        int rd0;
        int wr0;
        int log0;
        rd0 = rd_count;
        wr0 = wr_count;
        log0 = req_log.size();
        req.adr = adr;
        req.dat = dat;
        req.sel = sel;
        req.we = 1'b1;
        cpu_access(req, rdata, waits);
        compare_count("memory writes", wr_count - wr0, 1);
        compare_count("memory reads", rd_count - rd0, 0);
        if (req_log.size() > log0) begin
            compare_req("mem_req", req_log[log0], req);
        end
    endtask

    task automatic report_test(input string name, input int err0);
        if (errors == err0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - err0);
        end
    endtask

    task automatic test_read_miss_hit();
        logic [31:0] a;
        int err0;
        err0 = errors;
        a = line_addr(2, 5);
        check_read(a + 32'h08);
        check_read(a + 32'h08);
        check_read(a + 32'h3c);
        check_read(a);
        report_test("read miss then hit", err0);
    endtask

    task automatic test_write_hit();
        logic [31:0] a;
        logic [31:0] old;
        logic [31:0] merged;
        int err0;
        err0 = errors;
        a = line_addr(3, 9) + 32'h14;
        check_read(a);
        old = mem_model[a[15:2]];
        // bytes 0 and 2 from the write
        merged = {old[31:24], 8'had, old[15:8], 8'hef};
        check_write(a, 32'hdead_beef, 4'b0101);
        compare_word("memory word", mem_model[a[15:2]], merged);
        check_read(a);
        report_test("write-through on hit", err0);
    endtask

    task automatic test_write_miss();
        logic [31:0] a;
        int err0;
        err0 = errors;
        a = line_addr(4, 12) + 32'h20;
        check_write(a, 32'h1234_5678, 4'hf);
        compare_word("memory word", mem_model[a[15:2]], 32'h1234_5678);
        check_read(a);
        report_test("write miss without allocation", err0);
    endtask

    // fifth tag evicts way 0, the re-read then evicts way 1
    task automatic test_round_robin();
        int err0;
        err0 = errors;
        for (int t = 1; t <= 5; t++) begin
            check_read(line_addr(t, 20));
        end
        check_read(line_addr(1, 20));
        for (int t = 3; t <= 5; t++) begin
            check_read(line_addr(t, 20) + 32'h04);
        end
        report_test("round-robin replacement", err0);
    endtask

    task automatic test_random_reset();
        logic [31:0] a;
        logic [31:0] cached [$];
        int err0;
        err0 = errors;
        for (int i = 0; i < rand_ops; i++) begin
            a = line_addr(int'($urandom % 6) + 1, int'($urandom % 4) + 40);
            a = a + 32'((($urandom % 16)) << 2);
            if ($urandom % 3 == 0) begin
                check_write(a, $urandom, 4'($urandom % 15) + 4'd1);
            end else begin
                check_read(a);
            end
        end
        // lines the model holds before the reset
        for (int s = 40; s < 44; s++) begin
            for (int w = 0; w < cache_pkg::num_ways; w++) begin
                if (ref_valid[w][s]) begin
                    cached.push_back({ref_tag[w][s], 6'(s), 6'b0});
                end
            end
        end
        apply_reset();
        // model is clear now, every line must refill
        foreach (cached[i]) begin
            check_read(cached[i]);
        end
        report_test("set independence and reset", err0);
    endtask

    initial begin
        void'($urandom(32'h585a));
        arst_n = 1'b0;
        cpu_cyc = 1'b0;
        cpu_stb = 1'b0;
        cpu_req = '0;
        checks = 0;
        errors = 0;
        rd_count = 0;
        wr_count = 0;
        for (int i = 0; i < 16384; i++) begin
            mem_model[i] = fill_word(32'(i) << 2);
        end
        apply_reset();
        test_read_miss_hit();
        test_write_hit();
        test_write_miss();
        test_round_robin();
        test_random_reset();
        repeat (4) @(negedge clk);
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
logic/cache_pkg.sv
logic/cache_memory.sv
logic/memory.sv
logic/tag_store.sv
logic/mem_wr_ctrl.sv
logic/cache_ctrl.sv
logic/cache_top.sv
verification/cache_asserts.sv
verification/cache_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module cache_tb -f compile.f -o cache_sim

./obj_dir/cache_sim | tee sim.log

if grep -q "^TEST PASSED$" sim.log; then
    exit 0
fi
echo "simulation did not pass"
exit 1
